// File: tb.f
design/rtg_pkg.sv
design/rtg_word_fetch.sv
design/rtg_pixel_fifo.sv
design/rtg_beam_timer.sv
design/rtg_pixel_out.sv
design/rtg_display_top.sv
verification/rtg_display_asserts.sv
verification/rtg_display_tb.sv

// File: Makefile
# Verilator build of the display path testbench

VERILATOR ?= verilator
SIM_DIR   ?= sim_build
SEED      ?= 9190
LOG       ?= $(SIM_DIR)/sim.log

TOP  := rtg_display_tb
SRCS := $(shell grep -v '^+' tb.f)
BIN  := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) tb.f
	$(VERILATOR) --binary --assert --timing -Wno-fatal -f tb.f \
		--top-module $(TOP) -Gseed=$(SEED) -Mdir $(SIM_DIR) -o V$(TOP)

run: $(BIN)
	-$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(SIM_DIR)

// File: verification/rtg_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_display_tb;
	import rtg_pkg::*;

	parameter int seed = 32'h23e6;

	localparam int line_len       = 40;
	localparam int frame_lines    = 20;
	localparam int frames         = 5;
	localparam int run_cycles     = frames * frame_lines * line_len + 10;
	localparam int timeout_cycles = run_cycles * 3 / 2;

	logic       CLK_114 = 1'b0;
	logic       reset;
	logic       rtg_enable;
	addr_t      base_addr;
	logic [3:0] pixel_width;
	logic [6:0] vb_end;
	raster_s    raster;
	rgb_t       chip_rgb;
	logic       osd_window;
	logic       osd_pixel;
	logic       mem_req;
	addr_t      mem_addr;
	logic       mem_ready;
	mem_rsp_s   mem_rsp;
	logic       pixel_strobe;
	video_s     video;
	logic       underrun;

	int    cycles = 0;
	logic  stall;          // Memory refuses every read
	logic  prev_underrun;
	word_t rsp_data[$];    // Returns in flight, in order
	int    rsp_due[$];
	int    last_due = 0;

	rtg_display_top #(.fifo_depth(FIFO_DEPTH_DEFAULT)) dut0 (.*);

	always #10 CLK_114 = ~CLK_114;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////

	always @(posedge CLK_114) begin
		logic  acc;
		addr_t a;
		int    due;
		acc = mem_req && mem_ready;  // Pre-edge handshake
		a   = mem_addr;
		#1;
		if (acc) begin
			due = cycles + 1 + int'($urandom_range(3));
			if (due <= last_due) due = last_due + 1;  // Keep request order
			last_due = due;
			rsp_due.push_back(due);
			rsp_data.push_back(word_t'(a) ^ 16'h5a5a);
		end
		if (rsp_due.size() > 0 && rsp_due[0] <= cycles) begin
			mem_rsp <= '{valid: 1'b1, data: rsp_data.pop_front()};
			void'(rsp_due.pop_front());
		end else begin
			mem_rsp <= '0;
		end
		mem_ready <= !stall && ($urandom_range(7) != 0);  // Mostly ready
	end

	// Cycle budget and sticky underrun
	always @(posedge CLK_114) begin
		cycles        <= cycles + 1;
		prev_underrun <= underrun;
		if (cycles >= timeout_cycles) begin
			abort_run("Timeout: the frames did not complete within the cycle limit");
		end else if (dut0.u_asserts.errors != 0) begin
			abort_run("A bound assertion reported an error");
		end else if (!reset && prev_underrun && !underrun) begin
			abort_run($sformatf("CHECK FAILED underrun got %h expected %h", underrun, 1'b1));
		end
	end

	//////////////////////////////////////////////////
	// Raster stimulus
	//////////////////////////////////////////////////

	task automatic run_frame(input logic [3:0] width, input logic osd_on, input logic gap);
		for (int l = 0; l < frame_lines; l++) begin
			for (int c = 0; c < line_len; c++) begin
				@(posedge CLK_114);
				#1;
				raster.vblank = (l < 3);
				raster.hblank = (c < 8);
				raster.hsync  = (c < 8);
				raster.vsync  = (l == 0);
				pixel_width   = width;
				chip_rgb      = rgb_t'($urandom());
				osd_window    = osd_on && c >= 20 && c < 32;  // Box on each line
				osd_pixel     = c[1];
				rtg_enable    = !(gap && l >= 8 && l < 14);  // Native picture band
			end
		end
	endtask

	initial begin
		void'($urandom(seed));
		reset       = 1'b1;
		rtg_enable  = 1'b1;
		base_addr   = 24'h001200;
		pixel_width = 4'd1;
		vb_end      = 7'd2;
		raster      = '{hblank: 1'b1, vblank: 1'b1, hsync: 1'b0, vsync: 1'b1};
		chip_rgb    = '0;
		osd_window  = 1'b0;
		osd_pixel   = 1'b0;
		mem_ready   = 1'b0;
		mem_rsp     = '0;
		stall       = 1'b0;
		repeat (2) @(posedge CLK_114);
		#1;
		if (mem_req || pixel_strobe || underrun || video.blank) begin
			abort_run($sformatf("CHECK FAILED reset outputs got %h expected %h",
				{mem_req, pixel_strobe, underrun, video.blank}, 4'h0));
		end
		reset = 1'b0;
		run_frame(4'd1, 1'b0, 1'b0);
		run_frame(4'd1, 1'b1, 1'b0);  // OSD box
		run_frame(4'd1, 1'b0, 1'b1);  // rtg_enable dropped mid frame
		run_frame(4'd3, 1'b1, 1'b1);
		stall = 1'b1;                 // Starve the last frame
		run_frame(4'd3, 1'b0, 1'b0);
		repeat (4) @(posedge CLK_114);
		if (!underrun || dut0.u_asserts.errors != 0) begin
			abort_run("The stalled frame did not raise underrun, or an assertion failed");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/rtg_display_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_display_asserts #(
	parameter int fifo_depth = rtg_pkg::FIFO_DEPTH_DEFAULT
) (
	input logic              CLK_114,
	input logic              reset,
	input logic              rtg_enable,
	input rtg_pkg::addr_t    base_addr,
	input rtg_pkg::addr_t    mem_addr,
	input logic [3:0]        pixel_width,
	input logic [6:0]        vb_end,
	input rtg_pkg::raster_s  raster,
	input rtg_pkg::rgb_t     chip_rgb,
	input logic              osd_window,
	input logic              osd_pixel,
	input logic              mem_req,
	input logic              mem_ready,
	input logic              pixel_strobe,
	input logic              underrun,
	input rtg_pkg::video_s   video
);
	import rtg_pkg::*;

	localparam word_t data_key = 16'h5a5a;  // Memory model pattern

	int unsigned errors = 0;  // Failed checks so far
	logic        accept;
	int          ahead;        // Reads this frame not yet popped
	addr_t       exp_addr;
	addr_t       pop_k;        // Strobes since raw vblank
	logic [7:0]  since;        // Cycles since last strobe
	logic        run;          // Unbroken active stretch
	logic        hs_q;
	logic [6:0]  edges;        // Hsync rises since raw vblank fell
	logic        ref_ext;      // Stretched vblank
	logic        exp_blank;
	logic [2:0]  sync_d1;      // Blank, hsync, vsync
	logic [2:0]  sync_d2;
	rgb_t        exp_d1;
	rgb_t        exp_d2;
	logic        chk_d1;
	logic        chk_d2;
	logic        osd_w_d1;
	logic        osd_p_d1;

	function automatic rgb_t expand(input word_t w);
		rgb_t c;
		c.r = {w[14:10], w[14:12]};  // Top bits refill the low end
		c.g = {w[9:5], w[9:7]};
		c.b = {w[4:0], w[4:2]};
		return c;
	endfunction

	function automatic rgb_t overlay(input rgb_t c, input logic lit);
		osd_rgb_s v;
		v = lit ? OSD_ON_COLOUR : OSD_OFF_COLOUR;
		return '{r: {v.r, c.r[7:2]}, g: {v.g, c.g[7:2]}, b: {v.b, c.b[7:2]}};
	endfunction

	//////////////////////////////////////////////////
	// Reference state
	//////////////////////////////////////////////////

	assign accept    = mem_req & mem_ready;
	assign ahead     = int'(addr_t'(exp_addr - base_addr)) - int'(pop_k);
	assign exp_blank = ref_ext | raster.vblank | raster.hblank;

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			exp_addr    <= base_addr;
			pop_k       <= '0;
			since       <= '0;
			run         <= 1'b0;
			hs_q        <= 1'b0;
			edges       <= '0;
			ref_ext     <= 1'b0;
			sync_d1     <= '0;
			sync_d2     <= '0;
			chk_d1      <= 1'b0;
			chk_d2      <= 1'b0;
		end else begin
			if (raster.vblank) begin
				exp_addr <= base_addr;  // Frame restart
				pop_k    <= '0;
				edges    <= '0;
				ref_ext  <= 1'b1;
			end else begin
				if (accept) exp_addr <= exp_addr + addr_t'(1);
				if (pixel_strobe) pop_k <= pop_k + addr_t'(1);
				if (raster.hsync && !hs_q && edges != 7'h7f) edges <= edges + 7'd1;
				if (edges >= vb_end) ref_ext <= 1'b0;  // Extra lines done
			end
			since <= pixel_strobe ? 8'd0 : (since == 8'hff ? since : since + 8'd1);
			if (pixel_strobe) run <= 1'b1;
			else if (raster.hblank || raster.vblank || !rtg_enable) run <= 1'b0;
			hs_q     <= raster.hsync;
			sync_d1  <= {exp_blank, raster.hsync, raster.vsync};
			sync_d2  <= sync_d1;
			chk_d1   <= pixel_strobe & rtg_enable & ~underrun;  // Word from base+k
			exp_d1   <= expand(word_t'(base_addr + pop_k) ^ data_key);
			osd_w_d1 <= osd_window;
			osd_p_d1 <= osd_pixel;
			chk_d2   <= chk_d1 & rtg_enable & ~underrun;
			exp_d2   <= osd_w_d1 ? overlay(exp_d1, osd_p_d1) : exp_d1;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_credit: assert property (@(posedge CLK_114) disable iff (reset)
		ahead <= fifo_depth)
		else begin
			errors++;
			$error("CHECK FAILED reads ahead got %h limit %h", ahead, fifo_depth);
		end

	a_addr: assert property (@(posedge CLK_114) disable iff (reset)
		accept && !raster.vblank |-> mem_addr == exp_addr)
		else begin
			errors++;
			$error("CHECK FAILED mem_addr got %h expected %h", mem_addr, exp_addr);
		end

	a_gap: assert property (@(posedge CLK_114) disable iff (reset)
		pixel_strobe && run |-> since == 8'(pixel_width))
		else begin
			errors++;
			$error("CHECK FAILED strobe gap got %h expected %h", since, pixel_width);
		end

	a_blank: assert property (@(posedge CLK_114) disable iff (reset)
		pixel_strobe |-> !raster.hblank && !raster.vblank && edges >= vb_end)
		else begin
			errors++;
			$error("CHECK FAILED pixel_strobe in blank, edges %h vb_end %h", edges, vb_end);
		end

	a_sync: assert property (@(posedge CLK_114) disable iff (reset)
		{video.blank, video.hsync, video.vsync} == sync_d2)
		else begin
			errors++;
			$error("CHECK FAILED video blank hsync vsync got %h expected %h",
				{video.blank, video.hsync, video.vsync}, sync_d2);
		end

	a_pixel: assert property (@(posedge CLK_114) disable iff (reset)
		chk_d2 |-> video.colour == exp_d2)
		else begin
			errors++;
			$error("CHECK FAILED video.colour got %h expected %h", video.colour, exp_d2);
		end

	a_chip: assert property (@(posedge CLK_114) disable iff (reset)
		!$past(reset) && !$past(reset, 2) && !$past(rtg_enable) && !$past(osd_window, 2)
		|-> video.colour == $past(chip_rgb, 2))
		else begin
			errors++;
			$error("CHECK FAILED video.colour got %h expected %h",
				video.colour, $past(chip_rgb, 2));
		end

endmodule

bind rtg_display_top rtg_display_asserts #(.fifo_depth(fifo_depth)) u_asserts (.*);

`default_nettype wire

// File: design/rtg_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_display_top #(
	parameter int fifo_depth = rtg_pkg::FIFO_DEPTH_DEFAULT  // Power of two, 2 to 32
) (
	input  logic               CLK_114,
	input  logic               reset,
	input  logic               rtg_enable,   // Retargetable screen on
	input  rtg_pkg::addr_t     base_addr,    // Frame start in memory
	input  logic [3:0]         pixel_width,  // Clocks per pixel minus one
	input  logic [6:0]         vb_end,       // Extra vblank lines
	input  rtg_pkg::raster_s   raster,
	input  rtg_pkg::rgb_t      chip_rgb,     // Native chipset colour
	input  logic               osd_window,
	input  logic               osd_pixel,
	output logic               mem_req,
	output rtg_pkg::addr_t     mem_addr,
	input  logic               mem_ready,
	input  rtg_pkg::mem_rsp_s  mem_rsp,
	output logic               pixel_strobe,
	output rtg_pkg::video_s    video,
	output logic               underrun      // Sticky FIFO starvation
);
	import rtg_pkg::*;

	word_t   head_word;   // FIFO head, one cycle after the strobe
	logic    credit_ret;  // One credit back per pop
	raster_s raster_d2;   // Sync aligned to head_word
	logic    blank_d2;    // Blank aligned to head_word

	//////////////////////////////////////////////////
	// Fetch and buffer
	//////////////////////////////////////////////////

	rtg_word_fetch #(.fifo_depth(fifo_depth)) u_fetch (
		.CLK_114    (CLK_114),
		.reset      (reset),
		.rtg_enable (rtg_enable),
		.vblank     (raster.vblank),  // Raw vblank restarts the frame
		.base_addr  (base_addr),
		.credit_ret (credit_ret),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ready  (mem_ready)
	);

	rtg_pixel_fifo #(.fifo_depth(fifo_depth)) u_fifo (
		.CLK_114    (CLK_114),
		.reset      (reset),
		.flush      (raster.vblank),  // Same raw vblank as the fetcher
		.mem_rsp    (mem_rsp),
		.pop        (pixel_strobe),
		.head_word  (head_word),
		.credit_ret (credit_ret),
		.underrun   (underrun)
	);

	//////////////////////////////////////////////////
	// Beam timing and video out
	//////////////////////////////////////////////////

	rtg_beam_timer u_beam (
		.CLK_114      (CLK_114),
		.reset        (reset),
		.rtg_enable   (rtg_enable),
		.pixel_width  (pixel_width),
		.vb_end       (vb_end),
		.raster       (raster),
		.pixel_strobe (pixel_strobe),
		.raster_d2    (raster_d2),
		.blank_d2     (blank_d2)
	);

	rtg_pixel_out u_out (
		.CLK_114    (CLK_114),
		.reset      (reset),
		.rtg_enable (rtg_enable),
		.head_word  (head_word),
		.chip_rgb   (chip_rgb),
		.blank_d2   (blank_d2),
		.raster_d2  (raster_d2),
		.osd_window (osd_window),
		.osd_pixel  (osd_pixel),
		.video      (video)
	);

endmodule

`default_nettype wire

// File: design/rtg_pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_pixel_out (
	input  logic             CLK_114,
	input  logic             reset,
	input  logic             rtg_enable,
	input  rtg_pkg::word_t   head_word,   // Bit 15 not displayed
	input  rtg_pkg::rgb_t    chip_rgb,
	input  logic             blank_d2,
	input  rtg_pkg::raster_s raster_d2,
	input  logic             osd_window,
	input  logic             osd_pixel,
	output rtg_pkg::video_s  video
);
	import rtg_pkg::*;

	rgb_t     rtg_rgb;       // Expanded high-colour word
	rgb_t     chip_d;        // Native colour aligned to head_word
	rgb_t     src_rgb;
	rgb_t     osd_rgb;
	logic     osd_window_d;
	logic     osd_pixel_d;
	osd_rgb_s osd_val;

	// 5 bits to 8 by repeating the top three
	assign rtg_rgb.r = {head_word[14:10], head_word[14:12]};
	assign rtg_rgb.g = {head_word[9:5], head_word[9:7]};
	assign rtg_rgb.b = {head_word[4:0], head_word[4:2]};

	assign src_rgb = (rtg_enable && !blank_d2) ? rtg_rgb : chip_d;  // Native in blank

	assign osd_val   = osd_pixel_d ? OSD_ON_COLOUR : OSD_OFF_COLOUR;
	assign osd_rgb.r = {osd_val.r, src_rgb.r[7:2]};  // Picture dimmed under the OSD
	assign osd_rgb.g = {osd_val.g, src_rgb.g[7:2]};
	assign osd_rgb.b = {osd_val.b, src_rgb.b[7:2]};

	always_ff @(posedge CLK_114) begin
		chip_d      <= chip_rgb;
		osd_pixel_d <= osd_pixel;
	end

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			osd_window_d <= 1'b0;
			video        <= '0;
		end else begin
			osd_window_d <= osd_window;
			video.colour <= osd_window_d ? osd_rgb : src_rgb;
			video.blank  <= blank_d2;
			video.hsync  <= raster_d2.hsync;
			video.vsync  <= raster_d2.vsync;
		end
	end

endmodule

`default_nettype wire

// File: design/rtg_beam_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_beam_timer (
	input  logic             CLK_114,
	input  logic             reset,
	input  logic             rtg_enable,
	input  logic [3:0]       pixel_width,   // Strobe period minus one
	input  logic [6:0]       vb_end,        // Lines added after raw vblank
	input  rtg_pkg::raster_s raster,
	output logic             pixel_strobe,  // Pops the FIFO
	output rtg_pkg::raster_s raster_d2,
	output logic             blank_d2
);

	logic       hsync_q;     // For rising edge detect
	logic       ext_vblank;  // Stretched vblank
	logic [6:0] vb_count;    // Hsync edges since raw vblank fell
	logic [3:0] pixel_ctr;
	logic       blank;

	//////////////////////////////////////////////////
	// Vertical blank extension
	//////////////////////////////////////////////////

	// Counts lines by hsync rising edges once raw vblank drops
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			hsync_q    <= 1'b0;
			ext_vblank <= 1'b0;
			vb_count   <= '0;
		end else begin
			hsync_q <= raster.hsync;
			if (raster.vblank) begin
				ext_vblank <= 1'b1;  // Rises one cycle after raw
				vb_count   <= '0;
			end else if (vb_count == vb_end) begin
				ext_vblank <= 1'b0;  // Extension done
			end else if (raster.hsync && !hsync_q) begin
				vb_count <= vb_count + 7'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Pixel strobe
	//////////////////////////////////////////////////

	// Raw vblank covers the first cycle before ext_vblank is set
	assign blank        = ext_vblank | raster.vblank | raster.hblank;
	assign pixel_strobe = rtg_enable & ~blank & (pixel_ctr == pixel_width);

	always_ff @(posedge CLK_114) begin
		if (reset || blank || pixel_strobe) begin
			pixel_ctr <= '0;  // Restart each pixel and each line
		end else begin
			pixel_ctr <= pixel_ctr + 4'd1;
		end
	end

	// Matches the FIFO head register
	// Video register in rtg_pixel_out adds the second stage
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			blank_d2  <= 1'b0;
			raster_d2 <= '0;
		end else begin
			blank_d2  <= blank;
			raster_d2 <= raster;
		end
	end

endmodule

`default_nettype wire

// File: design/rtg_pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_pixel_fifo #(
	parameter int fifo_depth = rtg_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic              CLK_114,
	input  logic              reset,
	input  logic              flush,       // Raw vblank
	input  rtg_pkg::mem_rsp_s mem_rsp,     // Straight from memory
	input  logic              pop,         // Pixel strobe
	output rtg_pkg::word_t    head_word,   // Valid the cycle after pop
	output logic              credit_ret,  // Pulse per real pop
	output logic              underrun     // Sticky until reset
);
	import rtg_pkg::*;

	localparam int ptr_w = $clog2(fifo_depth);

	word_t          mem [fifo_depth];  // Circular store
	logic [ptr_w:0] wr_ptr;            // Extra bit tells full from empty
	logic [ptr_w:0] rd_ptr;
	logic           empty;
	logic           push;
	logic           do_pop;

	assign empty  = (wr_ptr == rd_ptr);
	assign push   = mem_rsp.valid & ~flush;  // Late returns in vblank dropped
	assign do_pop = pop & ~empty & ~flush;

	always_ff @(posedge CLK_114) begin
		if (push) begin
			mem[wr_ptr[ptr_w-1:0]] <= mem_rsp.data;
		end
	end

	// Head register loads a zero word on a starved pop
	always_ff @(posedge CLK_114) begin
		if (pop) begin
			head_word <= do_pop ? mem[rd_ptr[ptr_w-1:0]] : '0;
		end
	end

	always_ff @(posedge CLK_114) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + (ptr_w + 1)'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + (ptr_w + 1)'(1);
			end
		end
	end

	always_ff @(posedge CLK_114) begin
		if (reset) begin
			credit_ret <= 1'b0;
			underrun   <= 1'b0;
		end else begin
			credit_ret <= do_pop;  // Empty pop frees nothing
			if (pop && empty && !flush) begin
				underrun <= 1'b1;  // Memory fell behind the beam
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rtg_word_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rtg_word_fetch #(
	parameter int fifo_depth = rtg_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic           CLK_114,
	input  logic           reset,
	input  logic           rtg_enable,
	input  logic           vblank,      // Raw chipset vblank
	input  rtg_pkg::addr_t base_addr,
	input  logic           credit_ret,  // FIFO freed one slot
	output logic           mem_req,     // Held until accepted
	output rtg_pkg::addr_t mem_addr,
	input  logic           mem_ready
);
	import rtg_pkg::*;

	localparam int cnt_w = $clog2(fifo_depth + 1);
	localparam logic [cnt_w-1:0] credits_full = cnt_w'(fifo_depth);

	logic [cnt_w-1:0] credits;      // Free slots not yet claimed by a read
	logic [cnt_w-1:0] credits_nxt;
	logic             accept;       // Read handshake this cycle

	//////////////////////////////////////////////////
	// Credit accounting
	//////////////////////////////////////////////////

	assign accept      = mem_req & mem_ready;
	assign credits_nxt = credits - cnt_w'(accept) + cnt_w'(credit_ret);  // Spend and refund

	// Credits plus reads in flight plus stored words stay at fifo_depth,
	// so the FIFO cannot overflow
	always_ff @(posedge CLK_114) begin
		if (reset) begin
			credits  <= credits_full;
			mem_req  <= 1'b0;
			mem_addr <= base_addr;
		end else if (vblank) begin
			credits  <= credits_full;     // FIFO is flushed alongside
			mem_req  <= 1'b0;             // No fetch in vblank
			mem_addr <= base_addr;        // Next frame starts here
		end else begin
			credits <= credits_nxt;
			mem_req <= rtg_enable & (credits_nxt != '0);  // Pending read already paid
			if (accept) begin
				mem_addr <= mem_addr + addr_t'(1);  // Sequential words
			end
		end
	end

endmodule

`default_nettype wire

// File: design/rtg_pkg.sv
`default_nettype none

package rtg_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	localparam int WORD_W             = 16;  // One high-colour word
	localparam int ADDR_W             = 24;  // Word address space
	localparam int FIFO_DEPTH_DEFAULT = 8;   // Entries and credits

	typedef logic [WORD_W-1:0] word_t;  // x:5:5:5 pixel word
	typedef logic [ADDR_W-1:0] addr_t;  // Word address into memory

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;  // 8:8:8 colour

	typedef struct packed {
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} raster_s;  // Beam state from the chipset

	typedef struct packed {
		rgb_t colour;
		logic blank;
		logic hsync;
		logic vsync;
	} video_s;  // Registered video out

	typedef struct packed {
		logic  valid;
		word_t data;
	} mem_rsp_s;  // Read return, in request order

	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
	} osd_rgb_s;  // Top two bits per channel

	// OSD overlay values
	localparam osd_rgb_s OSD_ON_COLOUR  = '{r: 2'd3, g: 2'd3, b: 2'd3};  // Lit pixel
	localparam osd_rgb_s OSD_OFF_COLOUR = '{r: 2'd0, g: 2'd0, b: 2'd2};  // Dark blue

endpackage

`default_nettype wire
